/* logic/sdCardDefs.svh */
`ifndef SD_CARD_DEFS_SVH
`define SD_CARD_DEFS_SVH

// ==========================================================================
// Bus framing
// ==========================================================================
`define SD_CMD_BITS     48
`define SD_CRC7_BITS    7
`define SD_CRC16_BITS   16
`define SD_LANES        4

// Read blocks
`define SD_BLOCK_BYTES  512
`define SD_READ_GAP     2

// Cycles from respStart to the response start bit
`define SD_NCR_CYCLES   2

// ==========================================================================
// Fixed response words
// ==========================================================================
`define SD_RCA          16'hAAAA
`define SD_R1_STATUS    32'h00000900
`define SD_OCR_READY    32'hC1FF8080

`endif

/* logic/sdCardPkg.sv */
`include "sdCardDefs.svh"

package sdCardPkg;

    // App flag in bit 6, command index below
    typedef enum logic [6:0] {
        CMD0   = 7'd0,
        CMD3   = 7'd3,
        CMD7   = 7'd7,
        CMD8   = 7'd8,
        CMD12  = 7'd12,
        CMD18  = 7'd18,
        CMD55  = 7'd55,
        ACMD41 = 7'd105
    } sdCmd_t;

    typedef enum logic [1:0] {
        CtrlIdle,
        CtrlRespond,
        CtrlSettle
    } ctrlState_t;

    typedef enum logic [2:0] {
        RdIdle,
        RdStart,
        RdPayload,
        RdCrc,
        RdEnd,
        RdGap
    } readState_t;

    // x^7 + x^3 + 1, one bit per call
    function automatic logic [`SD_CRC7_BITS-1:0] crc7Next(
        input logic [`SD_CRC7_BITS-1:0] crc,
        input logic                     din
    );
        logic fb;
        fb = din ^ crc[6];
        return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
    endfunction

    // x^16 + x^12 + x^5 + 1
    function automatic logic [`SD_CRC16_BITS-1:0] crc16Next(
        input logic [`SD_CRC16_BITS-1:0] crc,
        input logic                      din
    );
        logic fb;
        fb = din ^ crc[15];
        return {crc[14:12], crc[11] ^ fb, crc[10:5], crc[4] ^ fb, crc[3:0], fb};
    endfunction

endpackage

/* logic/cmdReceiver.sv */
`timescale 1ns/1ps
`include "sdCardDefs.svh"

module cmdReceiver (
    input  logic        clk,
    input  logic        rst_,
    input  logic        cmdIn,
    output logic        cmdValid,
    output logic [5:0]  cmdIndex,
    output logic [31:0] cmdArg
);
    import sdCardPkg::*;

    // Bits covered by the CRC7
    localparam int CrcSpan = `SD_CMD_BITS - `SD_CRC7_BITS - 1;
    localparam int CntW = $clog2(`SD_CMD_BITS);

    logic                     active;
    logic [CntW-1:0]          bitCnt;
    logic [`SD_CMD_BITS-2:0]  shiftReg;
    logic [`SD_CRC7_BITS-1:0] crc;
    logic                     frameOk;

    // Checked while the end bit is still on cmdIn
    assign frameOk = shiftReg[`SD_CMD_BITS-3]
                     && (shiftReg[`SD_CRC7_BITS-1:0] == crc)
                     && cmdIn;

    always_ff @(posedge clk) begin
        if (!rst_) begin
            active   <= 1'b0;
            bitCnt   <= '0;
            crc      <= '0;
            cmdValid <= 1'b0;
        end else begin
            cmdValid <= 1'b0;
            if (!active) begin
                // Start bit
                if (!cmdIn) begin
                    active <= 1'b1;
                    bitCnt <= CntW'(1);
                    crc    <= crc7Next('0, cmdIn);
                end
            end else begin
                bitCnt <= bitCnt + 1'b1;
                if (bitCnt < CrcSpan) begin
                    crc <= crc7Next(crc, cmdIn);
                end
                if (bitCnt == `SD_CMD_BITS - 1) begin
                    active   <= 1'b0;
                    cmdValid <= frameOk;
                end
            end
        end
    end

    // Free-running shifter, stale bits fall out before the frame ends
    always_ff @(posedge clk) begin
        shiftReg <= {shiftReg[`SD_CMD_BITS-3:0], cmdIn};
        if (active && bitCnt == `SD_CMD_BITS - 1) begin
            cmdIndex <= shiftReg[44:39];
            cmdArg   <= shiftReg[38:7];
        end
    end

endmodule

/* logic/cardControl.sv */
`timescale 1ns/1ps
`include "sdCardDefs.svh"

module cardControl (
    input  logic        clk,
    input  logic        rst_,
    input  logic        cmdValid,
    input  logic [5:0]  cmdIndex,
    input  logic [31:0] cmdArg,
    input  logic        respDone,
    output logic        respStart,
    output logic        respNoCrc,
    output logic [5:0]  respIndex,
    output logic [31:0] respArg,
    output logic        readStart,
    output logic        readStop
);
    import sdCardPkg::*;

    ctrlState_t  state;
    sdCmd_t      op;
    sdCmd_t      lastOp;
    logic        appFlag;
    logic        selected;
    logic [15:0] rca;

    // Decoded response for the command on the inputs
    logic        needResp;
    logic [5:0]  nextIndex;
    logic [31:0] nextArg;
    logic        nextNoCrc;

    // Only ACMD41 takes the app bit, other indices after CMD55 decode as plain commands
    assign op = sdCmd_t'({appFlag && (cmdIndex == 6'd41), cmdIndex});

    // ======================================================================
    // Response decode
    // ======================================================================
    always_comb begin
        needResp  = 1'b1;
        nextIndex = cmdIndex;
        nextArg   = `SD_R1_STATUS;
        nextNoCrc = 1'b0;
        case (op)
            CMD0: begin
                needResp = 1'b0;
            end
            CMD3: begin
                nextArg = {`SD_RCA, 16'h0520};
            end
            CMD7: begin
                // Silent unless addressed to us
                needResp = (cmdArg[31:16] == rca);
                nextArg  = 32'h00000700;
            end
            CMD8: begin
                nextArg = {20'h00000, cmdArg[11:0]};
            end
            CMD12, CMD18: begin
                nextArg = `SD_R1_STATUS;
            end
            CMD55: begin
                nextArg = 32'h00000120;
            end
            ACMD41: begin
                nextIndex = 6'h3F;
                nextArg   = `SD_OCR_READY;
                nextNoCrc = 1'b1;
            end
            default: begin
                needResp = 1'b0;
            end
        endcase
    end

    // ======================================================================
    // Card state
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            state     <= CtrlIdle;
            appFlag   <= 1'b0;
            selected  <= 1'b0;
            rca       <= '0;
            respStart <= 1'b0;
        end else begin
            respStart <= 1'b0;
            case (state)
                CtrlIdle: begin
                    if (cmdValid) begin
                        appFlag <= (op == CMD55);
                        case (op)
                            CMD0: begin
                                rca      <= '0;
                                selected <= 1'b0;
                            end
                            CMD3: rca <= `SD_RCA;
                            CMD7: begin
                                if (needResp) begin
                                    selected <= 1'b1;
                                end
                            end
                            default: ;
                        endcase
                        if (needResp) begin
                            respStart <= 1'b1;
                            state     <= CtrlRespond;
                        end
                    end
                end
                CtrlRespond: begin
                    if (respDone) begin
                        state <= CtrlSettle;
                    end
                end
                // One cycle for the read strobes
                CtrlSettle: state <= CtrlIdle;
                default:    state <= CtrlIdle;
            endcase
        end
    end

    // Response fields held for the transmitter
    always_ff @(posedge clk) begin
        if (state == CtrlIdle && cmdValid) begin
            lastOp    <= op;
            respIndex <= nextIndex;
            respArg   <= nextArg;
            respNoCrc <= nextNoCrc;
        end
    end

    // Reads only stream to a selected card
    assign readStart = (state == CtrlSettle) && (lastOp == CMD18) && selected;
    assign readStop  = (state == CtrlSettle) && (lastOp == CMD12);

endmodule

/* logic/respTransmitter.sv */
`timescale 1ns/1ps
`include "sdCardDefs.svh"

module respTransmitter (
    input  logic        clk,
    input  logic        rst_,
    input  logic        respStart,
    input  logic        respNoCrc,
    input  logic [5:0]  respIndex,
    input  logic [31:0] respArg,
    output logic        cmdOut,
    output logic        cmdOe,
    output logic        respDone
);
    import sdCardPkg::*;

    // Start, transmission, index and argument
    localparam int HdrBits = `SD_CMD_BITS - `SD_CRC7_BITS - 1;
    localparam int CntW = $clog2(`SD_CMD_BITS);
    localparam int GapW = $clog2(`SD_NCR_CYCLES + 1);

    logic                     waiting;
    logic [GapW-1:0]          gapCnt;
    logic [CntW-1:0]          bitCnt;
    logic [HdrBits-1:0]       shiftReg;
    logic [`SD_CRC7_BITS-1:0] crc;
    logic                     noCrc;

    // ACMD41 sends ones in place of the CRC
    always_comb begin
        if (!cmdOe) begin
            cmdOut = 1'b1;
        end else if (bitCnt < HdrBits) begin
            cmdOut = shiftReg[HdrBits-1];
        end else if (bitCnt < `SD_CMD_BITS - 1) begin
            cmdOut = noCrc | crc[`SD_CRC7_BITS-1];
        end else begin
            cmdOut = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_) begin
            waiting  <= 1'b0;
            gapCnt   <= '0;
            bitCnt   <= '0;
            cmdOe    <= 1'b0;
            respDone <= 1'b0;
        end else begin
            respDone <= 1'b0;
            if (respStart) begin
                waiting <= 1'b1;
                gapCnt  <= GapW'(`SD_NCR_CYCLES - 1);
            end else if (waiting) begin
                // NCR gap
                gapCnt <= gapCnt - 1'b1;
                if (gapCnt == GapW'(1)) begin
                    waiting <= 1'b0;
                    cmdOe   <= 1'b1;
                    bitCnt  <= '0;
                end
            end else if (cmdOe) begin
                bitCnt <= bitCnt + 1'b1;
                if (bitCnt == `SD_CMD_BITS - 1) begin
                    cmdOe    <= 1'b0;
                    respDone <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (respStart) begin
            shiftReg <= {2'b00, respIndex, respArg};
            noCrc    <= respNoCrc;
        end else if (waiting) begin
            crc <= '0;
        end else if (cmdOe) begin
            if (bitCnt < HdrBits) begin
                crc      <= crc7Next(crc, shiftReg[HdrBits-1]);
                shiftReg <= shiftReg << 1;
            end else begin
                crc <= crc << 1;
            end
        end
    end

endmodule

/* logic/readDataTx.sv */
`timescale 1ns/1ps
`include "sdCardDefs.svh"

module readDataTx (
    input  logic                 clk,
    input  logic                 rst_,
    input  logic                 readStart,
    input  logic                 readStop,
    output logic [`SD_LANES-1:0] datOut,
    output logic                 datOe
);
    import sdCardPkg::*;

    localparam int NibCount = `SD_BLOCK_BYTES * 2;
    localparam int NibW = $clog2(NibCount);
    localparam int CrcW = $clog2(`SD_CRC16_BITS);
    localparam int GapW = $clog2(`SD_READ_GAP + 1);

    readState_t           state;
    logic [NibW-1:0]      nibCnt;
    logic [CrcW-1:0]      crcCnt;
    logic [GapW-1:0]      gapCnt;
    logic [7:0]           blkCnt;
    logic                 stopPending;
    logic [7:0]           byteVal;
    logic [`SD_LANES-1:0] nibble;

    logic [`SD_CRC16_BITS-1:0] crc [`SD_LANES];

    // Byte k of block b is (b + k) mod 256, high nibble first
    assign byteVal = blkCnt + nibCnt[8:1];
    assign nibble  = nibCnt[0] ? byteVal[3:0] : byteVal[7:4];

    // ======================================================================
    // Lane drive
    // ======================================================================
    always_comb begin
        datOe  = 1'b1;
        datOut = '1;
        case (state)
            RdStart:   datOut = '0;
            RdPayload: datOut = nibble;
            RdCrc: begin
                for (int i = 0; i < `SD_LANES; i++) begin
                    datOut[i] = crc[i][`SD_CRC16_BITS-1];
                end
            end
            RdEnd:     datOut = '1;
            default:   datOe = 1'b0;
        endcase
    end

    // ======================================================================
    // Block sequencer
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            state       <= RdIdle;
            nibCnt      <= '0;
            crcCnt      <= '0;
            gapCnt      <= '0;
            blkCnt      <= '0;
            stopPending <= 1'b0;
        end else begin
            if (readStop && state != RdIdle) begin
                stopPending <= 1'b1;
            end
            case (state)
                RdIdle: begin
                    if (readStart) begin
                        state       <= RdStart;
                        blkCnt      <= '0;
                        stopPending <= 1'b0;
                    end
                end
                RdStart: begin
                    state  <= RdPayload;
                    nibCnt <= '0;
                end
                RdPayload: begin
                    nibCnt <= nibCnt + 1'b1;
                    if (nibCnt == NibW'(NibCount - 1)) begin
                        state  <= RdCrc;
                        crcCnt <= '0;
                    end
                end
                RdCrc: begin
                    crcCnt <= crcCnt + 1'b1;
                    if (crcCnt == CrcW'(`SD_CRC16_BITS - 1)) begin
                        state <= RdEnd;
                    end
                end
                RdEnd: begin
                    blkCnt <= blkCnt + 1'b1;
                    // Stop only lands on a block boundary
                    if (stopPending || readStop) begin
                        state <= RdIdle;
                    end else begin
                        state  <= RdGap;
                        gapCnt <= GapW'(`SD_READ_GAP - 1);
                    end
                end
                RdGap: begin
                    gapCnt <= gapCnt - 1'b1;
                    if (stopPending || readStop) begin
                        state <= RdIdle;
                    end else if (gapCnt == '0) begin
                        state <= RdStart;
                    end
                end
                default: state <= RdIdle;
            endcase
        end
    end

    // Per-lane CRC16, shifted out MSB first after the payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < `SD_LANES; i++) begin
            if (state == RdStart) begin
                crc[i] <= '0;
            end else if (state == RdPayload) begin
                crc[i] <= crc16Next(crc[i], nibble[i]);
            end else if (state == RdCrc) begin
                crc[i] <= crc[i] << 1;
            end
        end
    end

endmodule

/* logic/sdCardEmu.sv */
`timescale 1ns/1ps
`include "sdCardDefs.svh"

module sdCardEmu (
    input  logic                 clk,
    input  logic                 rst_,
    input  logic                 cmdIn,
    output logic                 cmdOut,
    output logic                 cmdOe,
    output logic [`SD_LANES-1:0] datOut,
    output logic                 datOe
);

    // Command path
    logic        cmdValid;
    logic [5:0]  cmdIndex;
    logic [31:0] cmdArg;

    // Response path
    logic        respStart;
    logic        respNoCrc;
    logic [5:0]  respIndex;
    logic [31:0] respArg;
    logic        respDone;

    // Read path
    logic        readStart;
    logic        readStop;

    cmdReceiver i_cmdReceiver (
        .clk      (clk),
        .rst_     (rst_),
        .cmdIn    (cmdIn),
        .cmdValid (cmdValid),
        .cmdIndex (cmdIndex),
        .cmdArg   (cmdArg)
    );

    cardControl i_cardControl (
        .clk       (clk),
        .rst_      (rst_),
        .cmdValid  (cmdValid),
        .cmdIndex  (cmdIndex),
        .cmdArg    (cmdArg),
        .respDone  (respDone),
        .respStart (respStart),
        .respNoCrc (respNoCrc),
        .respIndex (respIndex),
        .respArg   (respArg),
        .readStart (readStart),
        .readStop  (readStop)
    );

    respTransmitter i_respTransmitter (
        .clk       (clk),
        .rst_      (rst_),
        .respStart (respStart),
        .respNoCrc (respNoCrc),
        .respIndex (respIndex),
        .respArg   (respArg),
        .cmdOut    (cmdOut),
        .cmdOe     (cmdOe),
        .respDone  (respDone)
    );

    readDataTx i_readDataTx (
        .clk       (clk),
        .rst_      (rst_),
        .readStart (readStart),
        .readStop  (readStop),
        .datOut    (datOut),
        .datOe     (datOe)
    );

endmodule

/* tests/sdCardEmu_props.sv */
`timescale 1ns/1ps
`include "sdCardDefs.svh"

module sdCardEmuProps (
    input logic                 clk,
    input logic                 rst_,
    input logic                 cmdOut,
    input logic                 cmdOe,
    input logic [`SD_LANES-1:0] datOut,
    input logic                 datOe
);

    // Both drivers off right after reset
    assert property (@(posedge clk) $rose(rst_) |-> !cmdOe && !datOe)
        else $error("Output enable high after reset release");

    // Response start bit
    assert property (@(posedge clk) disable iff (!rst_) $rose(cmdOe) |-> !cmdOut)
        else $error("Response does not begin with a start bit");

    assert property (@(posedge clk) disable iff (!rst_) $rose(datOe) |-> datOut == '0)
        else $error("Data block does not begin with start bits");

    // Last driven cycle carries the end bits
    assert property (@(posedge clk) disable iff (!rst_) $fell(datOe) |-> $past(datOut) == '1)
        else $error("Data block does not end with end bits");

endmodule

bind sdCardEmu sdCardEmuProps i_sdCardEmuProps (.*);

/* tests/sdCardMonitor.sv */
`timescale 1ns/1ps
`include "sdCardDefs.svh"

module sdCardMonitor (
    input logic                 clk,
    input logic                 rst_,
    input logic                 cmdIn,
    input logic                 cmdOut,
    input logic                 cmdOe,
    input logic [`SD_LANES-1:0] datOut,
    input logic                 datOe
);
    localparam int RespDelay = 2 + `SD_NCR_CYCLES;
    localparam int Nibbles = `SD_BLOCK_BYTES * 2;

    int errors = 0;
    int tests = 0;
    int cyc, endCyc, rxCnt, respCnt, pos, blk, startErrors, blkErrors;
    logic [47:0] rxSh, respSh;
    logic [39:0] expResp;
    logic [5:0]  lastIdx;
    logic [15:0] rca;
    logic [7:0]  byteVal;
    logic [3:0]  nib;
    logic [15:0] laneCrc [`SD_LANES];
    logic rx, appFlag, selected, expPending, quietWatch, readArmed, stopReq;

    // ======================================================================
    // Reference model
    // ======================================================================
    function automatic logic [6:0] calcCrc7(input logic [39:0] bits);
        logic [6:0] c;
        logic fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ c[6];
            c = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    function automatic logic [15:0] stepCrc16(input logic [15:0] c, input logic b);
        logic fb;
        fb = b ^ c[15];
        return {c[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
    endfunction

    // {has response, no CRC, index, argument}
    function automatic logic [39:0] refResponse(input logic [5:0] idx,
                                                input logic [31:0] arg,
                                                input logic app,
                                                input logic [15:0] rcaNow);
        logic [39:0] r;
        r = '0;
        if (app && idx == 6'd41) begin
            r = {2'b11, 6'h3F, `SD_OCR_READY};
        end else begin
            case (idx)
                6'd3:         r = {2'b10, idx, `SD_RCA, 16'h0520};
                6'd7:         if (arg[31:16] == rcaNow) r = {2'b10, idx, 32'h00000700};
                6'd8:         r = {2'b10, idx, 20'h00000, arg[11:0]};
                6'd12, 6'd18: r = {2'b10, idx, `SD_R1_STATUS};
                6'd55:        r = {2'b10, idx, 32'h00000120};
                default:      r = '0;
            endcase
        end
        return r;
    endfunction

    task automatic reportMismatch(input string sig, input logic [31:0] exp,
                                  input logic [31:0] act);
        $display("Fail at %0t ns: %s expected %h, got %h", $time, sig, exp, act);
        errors++;
    endtask

    task automatic reportProblem(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic checkResponse();
        logic [6:0] crcExp;
        crcExp = expResp[38] ? 7'h7F : calcCrc7(respSh[47:8]);
        if (respSh[47:46] != 2'b00) reportMismatch("cmdOut start bits", 0, respSh[47:46]);
        if (respSh[45:40] != expResp[37:32])
            reportMismatch("cmdOut index", expResp[37:32], respSh[45:40]);
        if (respSh[39:8] != expResp[31:0])
            reportMismatch("cmdOut argument", expResp[31:0], respSh[39:8]);
        if (respSh[7:1] != crcExp) reportMismatch("cmdOut CRC7", crcExp, respSh[7:1]);
        if (!respSh[0]) reportMismatch("cmdOut end bit", 1, 0);
        $display("CMD%0d response: %s", lastIdx, errors == startErrors ? "ok" : "mismatch");
        tests++;
        expPending = 1'b0;
    endtask

    always @(posedge clk) begin
        if (!rst_) begin
            cyc = 0;
            rx = 0;
            respCnt = 0;
            pos = 0;
            blk = 0;
            appFlag = 0;
            selected = 0;
            rca = '0;
            expPending = 0;
            quietWatch = 0;
            readArmed = 0;
            stopReq = 0;
        end else begin
            cyc++;
            // Read blocks
            if (datOe) begin
                if (pos == 0) begin
                    blkErrors = errors;
                    if (!readArmed) reportProblem("data block without an active read");
                    for (int i = 0; i < `SD_LANES; i++) laneCrc[i] = '0;
                    if (datOut != 4'h0) reportMismatch("datOut start bits", 0, datOut);
                end else if (pos <= Nibbles) begin
                    byteVal = 8'(blk + (pos - 1) / 2);
                    nib = ((pos - 1) % 2) ? byteVal[3:0] : byteVal[7:4];
                    if (datOut != nib) reportMismatch("datOut payload", nib, datOut);
                    for (int i = 0; i < `SD_LANES; i++)
                        laneCrc[i] = stepCrc16(laneCrc[i], nib[i]);
                end else if (pos <= Nibbles + 16) begin
                    for (int i = 0; i < `SD_LANES; i++) begin
                        if (datOut[i] != laneCrc[i][Nibbles + 16 - pos])
                            reportMismatch($sformatf("datOut[%0d] CRC16", i),
                                           laneCrc[i][Nibbles + 16 - pos], datOut[i]);
                    end
                end else if (pos == Nibbles + 17) begin
                    if (datOut != 4'hF) reportMismatch("datOut end bits", 4'hF, datOut);
                end else if (pos == Nibbles + 18) begin
                    reportProblem("datOe held past the end bits");
                end
                pos++;
            end else if (pos != 0) begin
                if (pos < Nibbles + 18) reportProblem("data block cut short");
                $display("Read block %0d: %s", blk, errors == blkErrors ? "ok" : "mismatch");
                tests++;
                blk++;
                if (stopReq) begin
                    readArmed = 0;
                    stopReq = 0;
                    $display("Read stream ended after CMD12");
                end
                pos = 0;
            end

            // Responses
            if (cmdOe) begin
                if (respCnt == 0) begin
                    startErrors = errors;
                    if (!expPending) reportProblem("response sent where none was due");
                    else if (cyc - endCyc != RespDelay)
                        reportMismatch("cmdOe start cycle", RespDelay, cyc - endCyc);
                end
                respSh = {respSh[46:0], cmdOut};
                respCnt++;
                if (respCnt == 48) begin
                    if (expPending) checkResponse();
                    respCnt = 0;
                end
            end else if (respCnt != 0) begin
                reportProblem("response shorter than 48 bits");
                respCnt = 0;
            end
            if (expPending && respCnt == 0 && cyc - endCyc > RespDelay + 2) begin
                reportProblem($sformatf("no response to CMD%0d", lastIdx));
                tests++;
                expPending = 0;
            end
            if (quietWatch && cyc - endCyc >= RespDelay + 48) begin
                $display("CMD%0d: no response, as expected", lastIdx);
                tests++;
                quietWatch = 0;
            end

            // Host commands
            if (rx) begin
                rxSh = {rxSh[46:0], cmdIn};
                rxCnt++;
                if (rxCnt == 48) begin
                    rx = 0;
                    endCyc = cyc;
                    lastIdx = rxSh[45:40];
                    if (rxSh[46] && rxSh[0] && calcCrc7(rxSh[47:8]) == rxSh[7:1]) begin
                        expResp = refResponse(lastIdx, rxSh[39:8], appFlag, rca);
                        case (lastIdx)
                            6'd0: begin
                                rca = '0;
                                selected = 0;
                            end
                            6'd3: rca = `SD_RCA;
                            6'd7: if (expResp[39]) selected = 1;
                            6'd12: stopReq = 1;
                            6'd18: begin
                                if (selected) begin
                                    readArmed = 1;
                                    stopReq = 0;
                                    blk = 0;
                                end
                            end
                            default: ;
                        endcase
                        appFlag = (lastIdx == 6'd55);
                        expPending = expResp[39];
                        quietWatch = !expResp[39];
                    end else begin
                        quietWatch = 1;
                    end
                end
            end else if (!cmdIn && !cmdOe) begin
                rx = 1;
                rxCnt = 1;
                rxSh = '0;
            end
        end
    end

endmodule

/* tests/sdCardEmuTb.sv */
`timescale 1ns/1ps
`include "sdCardDefs.svh"

module sdCardEmuTb;

    localparam int ClkPeriod = 20;
    localparam int CmdSlots = 16;
    localparam int SlotCycles = 150;
    localparam int BlockCycles = `SD_BLOCK_BYTES * 2 + 18 + `SD_READ_GAP;
    localparam longint WatchdogNs =
        longint'(CmdSlots * SlotCycles + 3 * BlockCycles) * ClkPeriod * 3 / 2;

    logic                 clk;
    logic                 rst_;
    logic                 cmdIn;
    logic                 cmdOut;
    logic                 cmdOe;
    logic [`SD_LANES-1:0] datOut;
    logic                 datOe;

    int          resetErrors;
    logic [31:0] cmd8Arg;

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    sdCardEmu i_sdCardEmu (
        .clk    (clk),
        .rst_   (rst_),
        .cmdIn  (cmdIn),
        .cmdOut (cmdOut),
        .cmdOe  (cmdOe),
        .datOut (datOut),
        .datOe  (datOe)
    );

    sdCardMonitor i_sdCardMonitor (.*);

    // Host side CRC7 with x^7 + x^3 + 1
    function automatic logic [6:0] frameCrc7(input logic [39:0] bits);
        logic [6:0] c;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            c = {c[5:0], 1'b0} ^ ((bits[i] ^ c[6]) ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    task automatic idleCycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic sendCmd(input logic [5:0] idx, input logic [31:0] arg,
                           input logic badCrc);
        logic [39:0] head;
        logic [47:0] frame;
        head = {2'b01, idx, arg};
        frame = {head, frameCrc7(head) ^ {6'd0, badCrc}, 1'b1};
        for (int i = 47; i >= 0; i--) begin
            @(posedge clk);
            #1 cmdIn = frame[i];
        end
        @(posedge clk);
        #1 cmdIn = 1'b1;
    endtask

    // Wait for a whole response or sit out the response window
    task automatic awaitResponse(input logic expected);
        int n;
        n = 0;
        if (expected) begin
            while (!cmdOe && n < `SD_NCR_CYCLES + 10) begin
                @(posedge clk);
                n++;
            end
            while (cmdOe && n < 80) begin
                @(posedge clk);
                n++;
            end
        end else begin
            idleCycles(`SD_NCR_CYCLES + 56);
        end
        idleCycles(4 + $urandom % 17);
    endtask

    task automatic awaitDatOe(input logic level, input int limit);
        int n;
        n = 0;
        while (datOe !== level && n < limit) begin
            @(posedge clk);
            n++;
        end
    endtask

    initial begin
        #(WatchdogNs);
        $display("Timeout: the tests did not finish within %0d ns", WatchdogNs);
        $display("Simulation failed");
        $finish;
    end

    // ======================================================================
    // Command sequence
    // ======================================================================
    initial begin
        void'($urandom(39403));
        cmdIn = 1'b1;
        rst_ = 1'b0;
        resetErrors = 0;
        repeat (5) @(posedge clk);
        #1 rst_ = 1'b1;

        // Idle levels on all outputs
        repeat (20) begin
            @(negedge clk);
            if ({cmdOe, datOe, cmdOut, datOut} !== 7'b0011111) begin
                $display("Fail at %0t ns: {cmdOe, datOe, cmdOut, datOut} expected %b, got %b",
                         $time, 7'b0011111, {cmdOe, datOe, cmdOut, datOut});
                resetErrors++;
            end
        end
        $display("Reset: %s", resetErrors == 0 ? "outputs idle" : "mismatch");

        // Init sequence
        sendCmd(6'd0, 32'h0, 1'b0);
        awaitResponse(1'b0);
        cmd8Arg = $urandom;
        sendCmd(6'd8, cmd8Arg, 1'b0);
        awaitResponse(1'b1);
        sendCmd(6'd55, 32'h0, 1'b0);
        awaitResponse(1'b1);
        sendCmd(6'd41, 32'h40FF8000, 1'b0);
        awaitResponse(1'b1);
        sendCmd(6'd3, 32'h0, 1'b0);
        awaitResponse(1'b1);

        // Selection
        sendCmd(6'd7, 32'h12340000, 1'b0);
        awaitResponse(1'b0);
        sendCmd(6'd7, {`SD_RCA, 16'h0000}, 1'b0);
        awaitResponse(1'b1);

        // Bad frames
        sendCmd(6'd8, $urandom, 1'b1);
        awaitResponse(1'b0);
        sendCmd(6'd2, 32'h0, 1'b0);
        awaitResponse(1'b0);
        sendCmd(6'd8, $urandom, 1'b0);
        awaitResponse(1'b1);

        // Multi-block read stopped during block 1
        sendCmd(6'd18, 32'h0, 1'b0);
        awaitResponse(1'b1);
        awaitDatOe(1'b1, 200);
        awaitDatOe(1'b0, BlockCycles + 10);
        awaitDatOe(1'b1, 50);
        idleCycles(20);
        sendCmd(6'd12, 32'h0, 1'b0);
        awaitResponse(1'b1);
        awaitDatOe(1'b0, BlockCycles + 10);
        idleCycles(150);

        // CMD55 then CMD8 decodes as a plain CMD8
        // That clears the app flag and leaves ACMD41 unanswered
        sendCmd(6'd55, 32'h0, 1'b0);
        awaitResponse(1'b1);
        sendCmd(6'd8, $urandom, 1'b0);
        awaitResponse(1'b1);
        sendCmd(6'd41, 32'h40FF8000, 1'b0);
        awaitResponse(1'b0);

        idleCycles(10);
        $display("Tests: %0d, errors: %0d", i_sdCardMonitor.tests + 1,
                 i_sdCardMonitor.errors + resetErrors);
        if (i_sdCardMonitor.errors + resetErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sdCardEmu.f */
+incdir+logic
logic/sdCardPkg.sv
logic/cmdReceiver.sv
logic/cardControl.sv
logic/respTransmitter.sv
logic/readDataTx.sv
logic/sdCardEmu.sv
tests/sdCardEmu_props.sv
tests/sdCardMonitor.sv
tests/sdCardEmuTb.sv

/* run.sh */
#!/bin/sh
# Build and run the SD card emulator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sdCardEmu.f \
    --top-module sdCardEmuTb \
    -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation passed" sim.log; then
    exit 0
else
    exit 1
fi
